//--- sim/fp_misc_golden.txt
// op rm a b result flags, all hex, flags are NV DZ OF UF NX
// op 0 i2f.w, 1 i2f.wu, 2 fmin, 3 fmax, 4 sgnj, 5 sgnjn, 6 sgnjx
0 0 00000000 00000000 00000000 00
0 0 ffffffff 00000000 bf800000 00
0 0 80000000 00000000 cf000000 00
1 0 ffffffff 00000000 4f800000 01
1 1 ffffffff 00000000 4f7fffff 01
1 0 80000000 00000000 4f000000 00
0 0 00000064 00000000 42c80000 00
0 0 01000001 00000000 4b800000 01
0 3 01000001 00000000 4b800001 01
0 4 01000001 00000000 4b800001 01
0 1 feffffff 00000000 cb800000 01
0 2 feffffff 00000000 cb800001 01
0 3 feffffff 00000000 cb800000 01
0 0 01000003 00000000 4b800002 01
0 7 01000003 00000000 4b800002 01
2 0 3f800000 c0000000 c0000000 00
3 0 3f800000 c0000000 3f800000 00
2 0 00000000 80000000 80000000 00
2 0 80000000 00000000 80000000 00
3 0 00000000 80000000 00000000 00
3 0 80000000 00000000 00000000 00
2 0 c0400000 c0000000 c0400000 00
2 0 7fc00000 3f800000 3f800000 00
3 0 40000000 7fc00001 40000000 00
2 0 7fc00000 ffc00000 7fc00000 00
3 0 7f800001 3f800000 3f800000 10
2 0 7fa00000 7fc00000 7fc00000 10
4 0 3f800000 c0000000 bf800000 00
5 0 3f800000 c0000000 3f800000 00
6 0 bf800000 c0000000 3f800000 00
4 0 7f800001 80000000 ff800001 00
5 0 ffc12345 00000000 ffc12345 00
6 0 7fc00abc 80000000 ffc00abc 00

//--- files.f
verilog/fp_format_pkg.sv
verilog/fp_misc_ctrl_pkg.sv
verilog/fp_misc_issue.sv
verilog/fp_i2f.sv
verilog/fp_minmax_sgnj.sv
verilog/fp_misc_wb.sv
verilog/fp_misc_unit.sv
sim/fp_misc_tb.sv

//--- Bender.yml
package:
  name: fp_misc_unit

sources:
  - files:
      - verilog/fp_format_pkg.sv
      - verilog/fp_misc_ctrl_pkg.sv
      - verilog/fp_misc_issue.sv
      - verilog/fp_i2f.sv
      - verilog/fp_minmax_sgnj.sv
      - verilog/fp_misc_wb.sv
      - verilog/fp_misc_unit.sv
  - target: simulation
    files:
      - sim/fp_misc_tb.sv

//--- sim/fp_misc_tb.sv
`timescale 1ns/100ps

module fp_misc_tb;

    ////////////////////////////////////////
    // Setup

    localparam int MAX_VEC = 64;
    localparam string GOLDEN_PATH = "sim/fp_misc_golden.txt";

    logic clk = 1'b0;
    logic rst_n;

    // DUT ports
    logic in_valid;
    logic in_ready;
    fp_misc_ctrl_pkg::fp_misc_op_t in_op;
    fp_format_pkg::rm_t in_rm;
    fp_misc_ctrl_pkg::id_t in_id;
    fp_format_pkg::fp_word_t in_a;
    fp_format_pkg::fp_word_t in_b;
    logic out_valid;
    logic out_ready;
    fp_misc_ctrl_pkg::id_t out_id;
    fp_format_pkg::fp_word_t out_result;
    fp_format_pkg::fflags_t out_flags;

    // Golden vectors with one entry per file line
    logic [2:0]  vec_op [MAX_VEC];
    logic [2:0]  vec_rm [MAX_VEC];
    logic [31:0] vec_a [MAX_VEC];
    logic [31:0] vec_b [MAX_VEC];
    logic [31:0] vec_res [MAX_VEC];
    logic [4:0]  vec_flags [MAX_VEC];
    int num_vec = 0;
    logic loaded = 1'b0;

    // Vector indices waiting for their result in issue order
    int exp_q [$];
    int sent = 0;
    int checked = 0;
    int cur_vec = 0;
    integer seed = 57;

    fp_misc_unit uut (
        .clk        (clk),
        .rst_n      (rst_n),
        .in_valid   (in_valid),
        .in_ready   (in_ready),
        .in_op      (in_op),
        .in_rm      (in_rm),
        .in_id      (in_id),
        .in_a       (in_a),
        .in_b       (in_b),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_id     (out_id),
        .out_result (out_result),
        .out_flags  (out_flags)
    );

    // 4 ns period
    always #2 clk = ~clk;

    ////////////////////////////////////////
    // Helpers

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] expected);
        if (got !== expected) begin
            $display("ERROR at %0t: %s got %h expected %h", $time, name, got, expected);
            $display("Something failed");
            $fatal(1);
        end
    endtask

    // Lines starting with // and blank lines are skipped
    task automatic load_vectors();
        int fd;
        int n;
        string line;
        logic [31:0] f_op;
        logic [31:0] f_rm;
        logic [31:0] f_a;
        logic [31:0] f_b;
        logic [31:0] f_res;
        logic [31:0] f_flags;
        fd = $fopen(GOLDEN_PATH, "r");
        if (fd == 0) begin
            $display("Could not open the golden file %s", GOLDEN_PATH);
            $display("Something failed");
            $fatal(1);
        end
        while (!$feof(fd) && num_vec < MAX_VEC) begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() >= 2 && line.substr(0, 1) != "//") begin
                n = $sscanf(line, "%h %h %h %h %h %h", f_op, f_rm, f_a, f_b, f_res, f_flags);
                if (n == 6) begin
                    vec_op[num_vec] = f_op[2:0];
                    vec_rm[num_vec] = f_rm[2:0];
                    vec_a[num_vec] = f_a;
                    vec_b[num_vec] = f_b;
                    vec_res[num_vec] = f_res;
                    vec_flags[num_vec] = f_flags[4:0];
                    num_vec++;
                end
            end
        end
        $fclose(fd);
    endtask

    // Puts one vector on the issue port with the line index mod 8 as tag
    task automatic present_vector(input int idx);
        in_valid = 1'b1;
        in_op = fp_misc_ctrl_pkg::fp_misc_op_t'(vec_op[idx]);
        in_rm = vec_rm[idx];
        in_id = fp_misc_ctrl_pkg::id_t'(idx % 8);
        in_a = vec_a[idx];
        in_b = vec_b[idx];
        cur_vec = idx;
    endtask

    ////////////////////////////////////////
    // Transfer monitor sampling pre-edge values
    always @(posedge clk) begin : monitor
        int idx;
        if (rst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                $display("A result came out with no operation pending at %0t", $time);
                $display("Something failed");
                $fatal(1);
            end
            idx = exp_q.pop_front();
            check_value("out_id", out_id, idx % 8);
            check_value("out_result", out_result, vec_res[idx]);
            check_value("out_flags", out_flags, vec_flags[idx]);
            checked++;
        end
        // Accepted operations queue up in issue order
        if (rst_n && in_valid && in_ready) begin
            exp_q.push_back(sent);
            sent++;
        end
    end

    ////////////////////////////////////////
    // Watchdog allowing 20 cycles per vector plus slack
    initial begin : watchdog
        wait (loaded);
        repeat (num_vec * 20 + 100) @(posedge clk);
        $display("Timeout: only %0d of %0d results arrived", checked, num_vec);
        $display("Something failed");
        $fatal(1);
    end

    ////////////////////////////////////////
    // Main sequence
    initial begin : main
        rst_n = 1'b0;
        in_valid = 1'b0;
        in_op = fp_misc_ctrl_pkg::OP_I2F_W;
        in_rm = '0;
        in_id = '0;
        in_a = '0;
        in_b = '0;
        out_ready = 1'b0;

        load_vectors();
        if (num_vec == 0) begin
            $display("The golden file holds no vectors");
            $display("Something failed");
            $fatal(1);
        end
        loaded = 1'b1;

        // Reset held for 4 cycles
        // Registers settle after the first edge
        repeat (4) begin
            @(negedge clk);
            check_value("out_valid", out_valid, 0);
            check_value("in_ready", in_ready, 1);
        end
        rst_n = 1'b1;
        @(negedge clk);
        check_value("out_valid", out_valid, 0);
        check_value("in_ready", in_ready, 1);

        // Random back-pressure and random idle issue cycles
        while (checked < num_vec) begin
            @(negedge clk);
            out_ready = ({$random(seed)} % 3) != 0;
            // Port free when idle or the last vector was taken
            if (!in_valid || sent != cur_vec) begin
                in_valid = 1'b0;
                if (sent < num_vec && ({$random(seed)} % 4) != 0) begin
                    present_vector(sent);
                end
            end
        end

        // Nothing extra may follow the last result
        in_valid = 1'b0;
        out_ready = 1'b1;
        repeat (4) @(negedge clk);
        check_value("out_valid", out_valid, 0);
        // Drained pipeline accepts again
        check_value("in_ready", in_ready, 1);

        $display("Everything OK");
        $finish;
    end

endmodule

//--- verilog/fp_misc_unit.sv
`timescale 1ns/100ps

module fp_misc_unit (
    input  logic                          clk,
    input  logic                          rst_n,

    // Issue port
    input  logic                          in_valid,
    output logic                          in_ready,
    input  fp_misc_ctrl_pkg::fp_misc_op_t in_op,
    input  fp_format_pkg::rm_t            in_rm,
    input  fp_misc_ctrl_pkg::id_t         in_id,
    input  fp_format_pkg::fp_word_t       in_a,
    input  fp_format_pkg::fp_word_t       in_b,

    // Write-back port
    output logic                          out_valid,
    input  logic                          out_ready,
    output fp_misc_ctrl_pkg::id_t         out_id,
    output fp_format_pkg::fp_word_t       out_result,
    output fp_format_pkg::fflags_t        out_flags
);

    // Stage 1 handshake and payload
    logic s1_valid;
    logic s1_ready;
    fp_misc_ctrl_pkg::fp_misc_op_t s1_op;
    fp_format_pkg::rm_t s1_rm;
    fp_misc_ctrl_pkg::id_t s1_id;
    fp_format_pkg::fp_word_t s1_a;
    fp_format_pkg::fp_word_t s1_b;

    // Function module results
    fp_format_pkg::fp_word_t i2f_result;
    fp_format_pkg::fflags_t i2f_flags;
    fp_format_pkg::fp_word_t cmp_result;
    fp_format_pkg::fflags_t cmp_flags;

    ////////////////////////////////////////
    // Issue register
    fp_misc_issue issue_inst (
        .clk      (clk),
        .rst_n    (rst_n),
        .in_valid (in_valid),
        .in_ready (in_ready),
        .in_op    (in_op),
        .in_rm    (in_rm),
        .in_id    (in_id),
        .in_a     (in_a),
        .in_b     (in_b),
        .s1_ready (s1_ready),
        .s1_valid (s1_valid),
        .s1_op    (s1_op),
        .s1_rm    (s1_rm),
        .s1_id    (s1_id),
        .s1_a     (s1_a),
        .s1_b     (s1_b)
    );

    ////////////////////////////////////////
    // Function modules, both combinational
    fp_i2f i2f_inst (
        .s1_op      (s1_op),
        .s1_rm      (s1_rm),
        .s1_a       (s1_a),
        .i2f_result (i2f_result),
        .i2f_flags  (i2f_flags)
    );

    fp_minmax_sgnj minmax_sgnj_inst (
        .s1_op      (s1_op),
        .s1_a       (s1_a),
        .s1_b       (s1_b),
        .cmp_result (cmp_result),
        .cmp_flags  (cmp_flags)
    );

    ////////////////////////////////////////
    // Write-back register
    fp_misc_wb wb_inst (
        .clk        (clk),
        .rst_n      (rst_n),
        .s1_valid   (s1_valid),
        .s1_ready   (s1_ready),
        .s1_op      (s1_op),
        .s1_id      (s1_id),
        .i2f_result (i2f_result),
        .cmp_result (cmp_result),
        .i2f_flags  (i2f_flags),
        .cmp_flags  (cmp_flags),
        .out_valid  (out_valid),
        .out_ready  (out_ready),
        .out_id     (out_id),
        .out_result (out_result),
        .out_flags  (out_flags)
    );

endmodule

//--- verilog/fp_misc_wb.sv
`timescale 1ns/100ps

module fp_misc_wb (
    input  logic                          clk,
    input  logic                          rst_n,

    // Stage 1 results
    input  logic                          s1_valid,
    output logic                          s1_ready,
    input  fp_misc_ctrl_pkg::fp_misc_op_t s1_op,
    input  fp_misc_ctrl_pkg::id_t         s1_id,
    input  fp_format_pkg::fp_word_t       i2f_result,
    input  fp_format_pkg::fp_word_t       cmp_result,
    input  fp_format_pkg::fflags_t        i2f_flags,
    input  fp_format_pkg::fflags_t        cmp_flags,

    // Write-back port
    output logic                          out_valid,
    input  logic                          out_ready,
    output fp_misc_ctrl_pkg::id_t         out_id,
    output fp_format_pkg::fp_word_t       out_result,
    output fp_format_pkg::fflags_t        out_flags
);

    // Converter owns the two I2F codes
    logic is_i2f;

    ////////////////////////////////////////
    // Advance when empty or when the consumer takes it
    assign s1_ready = ~out_valid | out_ready;

    assign is_i2f = (s1_op == fp_misc_ctrl_pkg::OP_I2F_W) ||
                    (s1_op == fp_misc_ctrl_pkg::OP_I2F_WU);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (s1_ready) begin
            out_valid <= s1_valid;
        end
    end

    // Result held stable while stalled
    always_ff @(posedge clk) begin
        if (s1_ready && s1_valid) begin
            out_id     <= s1_id;
            out_result <= is_i2f ? i2f_result : cmp_result;
            out_flags  <= is_i2f ? i2f_flags : cmp_flags;
        end
    end

endmodule

//--- verilog/fp_minmax_sgnj.sv
`timescale 1ns/100ps

module fp_minmax_sgnj (
    input  fp_misc_ctrl_pkg::fp_misc_op_t s1_op,
    input  fp_format_pkg::fp_word_t       s1_a,
    input  fp_format_pkg::fp_word_t       s1_b,
    output fp_format_pkg::fp_word_t       cmp_result,
    output fp_format_pkg::fflags_t        cmp_flags
);

    // Operand classification
    logic a_sign;
    logic b_sign;
    logic a_nan;
    logic b_nan;
    logic a_snan;
    logic b_snan;

    // a strictly below b, -0 below +0
    logic a_lt_b;

    // Candidate results
    fp_format_pkg::fp_word_t minmax_val;
    fp_format_pkg::fp_word_t sgnj_val;
    logic new_sign;

    ////////////////////////////////////////
    // Classify
    assign a_sign = s1_a[31];
    assign b_sign = s1_b[31];

    // Exponent all ones with a nonzero mantissa
    assign a_nan = (&s1_a[30 -: fp_format_pkg::EXP_W]) & (|s1_a[fp_format_pkg::MANT_W-1:0]);
    assign b_nan = (&s1_b[30 -: fp_format_pkg::EXP_W]) & (|s1_b[fp_format_pkg::MANT_W-1:0]);

    // Signaling when the quiet bit is clear
    assign a_snan = a_nan & ~s1_a[fp_format_pkg::MANT_W-1];
    assign b_snan = b_nan & ~s1_b[fp_format_pkg::MANT_W-1];

    ////////////////////////////////////////
    // Sign-magnitude compare
    always_comb begin
        if (a_sign != b_sign) begin
            // Negative side is smaller, covers -0 vs +0
            a_lt_b = a_sign;
        end else if (a_sign) begin
            // Both negative, larger magnitude is smaller
            a_lt_b = s1_a[30:0] > s1_b[30:0];
        end else begin
            a_lt_b = s1_a[30:0] < s1_b[30:0];
        end
    end

    ////////////////////////////////////////
    // Min/max with NaN rules
    always_comb begin
        if (a_nan && b_nan) begin
            minmax_val = fp_format_pkg::CANON_NAN;
        end else if (a_nan) begin
            minmax_val = s1_b;
        end else if (b_nan) begin
            minmax_val = s1_a;
        end else if (s1_op == fp_misc_ctrl_pkg::OP_FMAX) begin
            minmax_val = a_lt_b ? s1_b : s1_a;
        end else begin
            minmax_val = a_lt_b ? s1_a : s1_b;
        end
    end

    ////////////////////////////////////////
    // Sign injection, magnitude of a untouched
    always_comb begin
        case (s1_op)
            fp_misc_ctrl_pkg::OP_SGNJN: new_sign = ~b_sign;
            fp_misc_ctrl_pkg::OP_SGNJX: new_sign = a_sign ^ b_sign;
            default: new_sign = b_sign;
        endcase
    end

    assign sgnj_val = {new_sign, s1_a[30:0]};

    ////////////////////////////////////////
    // Output select
    always_comb begin
        cmp_flags = '0;
        case (s1_op)
            fp_misc_ctrl_pkg::OP_FMIN,
            fp_misc_ctrl_pkg::OP_FMAX: begin
                cmp_result = minmax_val;
                // Quiet NaNs raise nothing
                cmp_flags[fp_format_pkg::FLAG_NV] = a_snan | b_snan;
            end
            // Sign injection never raises a flag
            default: cmp_result = sgnj_val;
        endcase
    end

endmodule

//--- verilog/fp_i2f.sv
`timescale 1ns/100ps

module fp_i2f (
    input  fp_misc_ctrl_pkg::fp_misc_op_t s1_op,
    input  fp_format_pkg::rm_t            s1_rm,
    input  fp_format_pkg::fp_word_t       s1_a,
    output fp_format_pkg::fp_word_t       i2f_result,
    output fp_format_pkg::fflags_t        i2f_flags
);

    // Signed source and sign of the result
    logic is_signed;
    logic sign;

    // Magnitude before and after normalization
    fp_format_pkg::int_word_t mag;
    fp_format_pkg::int_word_t norm;
    logic [5:0] lz;

    // Unrounded exponent and mantissa
    logic [fp_format_pkg::EXP_W-1:0] exp_biased;
    logic [fp_format_pkg::MANT_W-1:0] mant;

    // Bits shifted out below the mantissa
    logic guard;
    logic round_bit;
    logic sticky;
    logic inexact;
    logic round_up;

    // Exponent and mantissa after the increment
    logic [30:0] rounded;

    ////////////////////////////////////////
    // Leading zero count, 32 for zero
    function automatic logic [5:0] count_lz(input fp_format_pkg::int_word_t v);
        logic [5:0] n;
        logic found;
        n = 6'd32;
        found = 1'b0;
        for (int i = 31; i >= 0; i--) begin
            if (v[i] && !found) begin
                n = 6'(31 - i);
                found = 1'b1;
            end
        end
        return n;
    endfunction

    ////////////////////////////////////////
    // Magnitude

    // Only the W form treats bit 31 as sign
    assign is_signed = (s1_op == fp_misc_ctrl_pkg::OP_I2F_W);
    assign sign = is_signed & s1_a[31];
    // 0x80000000 negates to itself, still right as a magnitude
    assign mag = sign ? (~s1_a + 32'd1) : s1_a;

    ////////////////////////////////////////
    // Normalize

    assign lz = count_lz(mag);
    // Leading one lands in bit 31, the hidden bit
    assign norm = mag << lz;
    assign mant = norm[30 -: fp_format_pkg::MANT_W];
    // Value is 2^(31-lz) times 1.mant
    assign exp_biased = 8'(fp_format_pkg::EXP_BIAS + 31) - {2'b00, lz};

    // Guard, round and sticky from the eight dropped bits
    assign guard = norm[30 - fp_format_pkg::MANT_W];
    assign round_bit = norm[29 - fp_format_pkg::MANT_W];
    assign sticky = |norm[28 - fp_format_pkg::MANT_W:0];
    assign inexact = guard | round_bit | sticky;

    ////////////////////////////////////////
    // Rounding decision
    always_comb begin
        case (s1_rm)
            fp_format_pkg::RM_RTZ: round_up = 1'b0;
            // Toward -inf grows negative magnitudes
            fp_format_pkg::RM_RDN: round_up = sign & inexact;
            fp_format_pkg::RM_RUP: round_up = ~sign & inexact;
            // Ties away from zero
            fp_format_pkg::RM_RMM: round_up = guard;
            // RNE, also for the reserved codes 5 to 7
            default: round_up = guard & (round_bit | sticky | mant[0]);
        endcase
    end

    // Mantissa carry ripples into the exponent
    assign rounded = {exp_biased, mant} + {30'd0, round_up};

    ////////////////////////////////////////
    // Result and flags

    // Zero has no leading one, forced to +0
    assign i2f_result = (mag == '0) ? '0 : {sign, rounded};

    always_comb begin
        i2f_flags = '0;
        // Inexact is the only possible exception
        i2f_flags[fp_format_pkg::FLAG_NX] = inexact;
    end

endmodule

//--- verilog/fp_misc_issue.sv
`timescale 1ns/100ps

module fp_misc_issue (
    input  logic                          clk,
    input  logic                          rst_n,

    // Issue port
    input  logic                          in_valid,
    output logic                          in_ready,
    input  fp_misc_ctrl_pkg::fp_misc_op_t in_op,
    input  fp_format_pkg::rm_t            in_rm,
    input  fp_misc_ctrl_pkg::id_t         in_id,
    input  fp_format_pkg::fp_word_t       in_a,
    input  fp_format_pkg::fp_word_t       in_b,

    // Stage 1 towards the function modules
    input  logic                          s1_ready,
    output logic                          s1_valid,
    output fp_misc_ctrl_pkg::fp_misc_op_t s1_op,
    output fp_format_pkg::rm_t            s1_rm,
    output fp_misc_ctrl_pkg::id_t         s1_id,
    output fp_format_pkg::fp_word_t       s1_a,
    output fp_format_pkg::fp_word_t       s1_b
);

    // Transfer on the issue port
    logic take;

    ////////////////////////////////////////
    // Handshake

    // Room when empty or when stage 1 is drained this cycle
    assign in_ready = ~s1_valid | s1_ready;
    assign take = in_valid & in_ready;

    ////////////////////////////////////////
    // Valid bit
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid <= 1'b0;
        end else if (in_ready) begin
            // Refill or go empty
            s1_valid <= in_valid;
        end
    end

    ////////////////////////////////////////
    // Operation and operands
    always_ff @(posedge clk) begin
        if (take) begin
            s1_op <= in_op;
            s1_rm <= in_rm;
            s1_id <= in_id;
            // Integer source for conversions
            s1_a  <= in_a;
            s1_b  <= in_b;
        end
    end

endmodule

//--- verilog/fp_misc_ctrl_pkg.sv
package fp_misc_ctrl_pkg;

    ////////////////////////////////////////
    // Operation tag

    // Width of the id carried with each operation
    localparam int ID_W = 3;

    typedef logic [ID_W-1:0] id_t;

    ////////////////////////////////////////
    // Operation codes

    // Conversions first, then min/max, then sign injection
    typedef enum logic [2:0] {
        // Signed int to float
        OP_I2F_W  = 3'd0,
        // Unsigned int to float
        OP_I2F_WU = 3'd1,
        OP_FMIN   = 3'd2,
        OP_FMAX   = 3'd3,
        // Sign of b
        OP_SGNJ   = 3'd4,
        // Inverted sign of b
        OP_SGNJN  = 3'd5,
        // Sign of a xor sign of b
        OP_SGNJX  = 3'd6
    } fp_misc_op_t;

endpackage

//--- verilog/fp_format_pkg.sv
package fp_format_pkg;

    ////////////////////////////////////////
    // Word types

    // Single-precision value, sign/exponent/mantissa
    typedef logic [31:0] fp_word_t;

    // Integer operand of a conversion
    typedef logic [31:0] int_word_t;

    // Exception flags NV DZ OF UF NX, NV on top
    typedef logic [4:0] fflags_t;

    // Rounding mode field as in the fcsr
    typedef logic [2:0] rm_t;

    ////////////////////////////////////////
    // Format constants
    localparam int EXP_BIAS = 127;
    localparam int MANT_W = 23;
    localparam int EXP_W = 8;

    // Quiet NaN with empty payload
    localparam fp_word_t CANON_NAN = 32'h7fc0_0000;

    // Flag positions inside fflags_t
    localparam int FLAG_NV = 4;
    localparam int FLAG_NX = 0;

    ////////////////////////////////////////
    // Rounding modes, RISC-V encoding
    localparam rm_t RM_RNE = 3'd0;
    localparam rm_t RM_RTZ = 3'd1;
    localparam rm_t RM_RDN = 3'd2;
    localparam rm_t RM_RUP = 3'd3;
    localparam rm_t RM_RMM = 3'd4;

endpackage
